/* ahb_fabric_top.f */
hdl/ahb_bus_pkg.sv
hdl/ahb_map_pkg.sv
hdl/ahb_decoder.sv
hdl/ahb_default_slave.sv
hdl/ahb_resp_mux.sv
hdl/ahb_sram_slave.sv
hdl/ahb_fabric_top.sv
testbench/tb_ahb_fabric.sv

/* run_sim.sh */
#!/bin/sh
# build the AHB-Lite fabric testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing \
  -f ahb_fabric_top.f \
  --top-module tb_ahb_fabric \
  -o tb_ahb_fabric

status=0
out=$(./obj_dir/tb_ahb_fabric 2>&1) || status=$?
printf '%s\n' "$out"

# a missing pass line fails the script here
printf '%s\n' "$out" | grep -q "^Result: PASSED$"
exit "$status"

/* testbench/tb_ahb_fabric.sv */
`timescale 1ns/1ps
// testbench for the AHB-Lite fabric: clock, reset, LFSR stimulus,
// reference memory per slave and the checking assertions
module tb_ahb_fabric;

  // data phase as seen from the master side
  typedef struct packed
  {
    logic       valid;
    logic       write;
    logic       err;
    logic [1:0] slave;
    logic [7:0] index;
  } dphase_t;

  logic                   hclk;
  logic                   hreset_n;
  logic                   hremap;
  ahb_bus_pkg::ahb_req_t  req;
  ahb_bus_pkg::ahb_resp_t resp;

  // reference memory, row 3 takes unmapped phases
  logic [31:0] model [4][256];
  // words with a write already issued
  bit          written [4][256];
  dphase_t     dp;
  int unsigned low_cnt;
  logic        ready_smp;
  logic [31:0] exp_rdata;
  int unsigned exp_wait;
  logic [31:0] lfsr;
  logic [31:0] wdata_next;
  int          fail_count;

  initial
  begin
    hclk = 1'b0;
    forever #10 hclk = ~hclk;
  end

  ahb_fabric_top ahb_fabric_top_inst
  (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .hremap   (hremap),
    .req      (req),
    .resp     (resp)
  );

  // ============================================================
  // helpers
  // ============================================================
  task automatic stop_with_failure(input string what);
    fail_count++;
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
    stop_with_failure($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, got));
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // address map: page 0 slave 0, page 1 slave 1, page 4 slave 2,
  // remap swaps pages 0 and 1, 3 means unmapped
  function automatic logic [1:0] slave_of(input logic [31:0] addr, input logic remap);
    logic [21:0] page;
    page = addr[31:10];
    case (page)
      22'd0:   slave_of = remap ? 2'd1 : 2'd0;
      22'd1:   slave_of = remap ? 2'd0 : 2'd1;
      22'd4:   slave_of = 2'd2;
      default: slave_of = 2'd3;
    endcase
  endfunction

  // ============================================================
  // data-phase tracker and reference model
  // ============================================================
  // hreadyout is stable at the falling edge
  always @(negedge hclk)
    ready_smp <= resp.hreadyout;

  always @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      dp      <= '0;
      low_cnt <= 0;
    end
    else if (ready_smp)
    begin
      // completed write lands in the model
      if (dp.valid && dp.write && !dp.err)
        model[dp.slave][dp.index] <= req.hwdata;
      dp.valid <= (req.htrans == ahb_bus_pkg::NONSEQ) || (req.htrans == ahb_bus_pkg::SEQ);
      dp.write <= req.hwrite;
      dp.slave <= slave_of(req.haddr, hremap);
      dp.err   <= (slave_of(req.haddr, hremap) == 2'd3);
      dp.index <= req.haddr[9:2];
      low_cnt  <= 0;
    end
    else
      low_cnt <= low_cnt + 1;
  end

  always_comb
  begin
    exp_rdata = model[dp.slave][dp.index];
    // slave 0 zero wait, slave 1 one, slave 2 two
    case (dp.slave)
      2'd0:    exp_wait = 0;
      2'd1:    exp_wait = 1;
      2'd2:    exp_wait = 2;
      default: exp_wait = 0;
    endcase
  end

  // ============================================================
  // checks
  // ============================================================
  // no owner, idle bus answer
  a_idle_okay: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    !dp.valid |-> (resp.hreadyout && (resp.hresp == ahb_bus_pkg::OKAY))
  ) else report_value("resp.hreadyout/hresp", 32'h2,
                      32'({$sampled(resp.hreadyout), $sampled(resp.hresp)}));

  a_sram_okay: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (dp.valid && !dp.err) |-> (resp.hresp == ahb_bus_pkg::OKAY)
  ) else report_value("resp.hresp", 32'h0, 32'($sampled(resp.hresp)));

  a_read_data: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (dp.valid && !dp.err && !dp.write && resp.hreadyout) |-> (resp.hrdata == exp_rdata)
  ) else report_value("resp.hrdata", $sampled(exp_rdata), $sampled(resp.hrdata));

  // low cycles before completion equal the slave's wait states
  a_wait_count: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (dp.valid && !dp.err && resp.hreadyout) |-> (low_cnt == exp_wait)
  ) else report_value("hreadyout low cycles", 32'($sampled(exp_wait)),
                      32'($sampled(low_cnt)));

  a_wait_bound: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (dp.valid && !dp.err) |-> (low_cnt <= exp_wait)
  ) else report_value("hreadyout low cycles", 32'($sampled(exp_wait)),
                      32'($sampled(low_cnt)));

  // two-cycle ERROR, first with hreadyout low
  a_err_first: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (dp.valid && dp.err && (low_cnt == 0)) |->
      (!resp.hreadyout && (resp.hresp == ahb_bus_pkg::ERROR))
  ) else report_value("resp.hreadyout/hresp", 32'h1,
                      32'({$sampled(resp.hreadyout), $sampled(resp.hresp)}));

  a_err_second: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (dp.valid && dp.err && (low_cnt != 0)) |->
      (resp.hreadyout && (resp.hresp == ahb_bus_pkg::ERROR))
  ) else report_value("resp.hreadyout/hresp", 32'h3,
                      32'({$sampled(resp.hreadyout), $sampled(resp.hresp)}));

  // ============================================================
  // stimulus
  // ============================================================
  // returns on the edge that accepts the address phase
  task automatic do_transfer(input logic [31:0] addr, input logic write,
                             input logic [31:0] wdata, input ahb_bus_pkg::htrans_t trans);
    int n;
    req.haddr  <= addr;
    req.htrans <= trans;
    req.hwrite <= write;
    req.hsize  <= ahb_bus_pkg::WORD;
    // hwdata belongs to the previous address phase
    req.hwdata <= wdata_next;
    wdata_next = write ? wdata : 32'd0;
    n = 0;
    do
    begin
      @(negedge hclk);
      n++;
      if (n > 16)
        stop_with_failure("hready never returned");
    end
    while (!resp.hreadyout);
    @(posedge hclk);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    written[slave_of(addr, 1'b0)][addr[9:2]] = 1'b1;
    do_transfer(addr, 1'b1, data, ahb_bus_pkg::NONSEQ);
  endtask

  task automatic read_word(input logic [31:0] addr);
    do_transfer(addr, 1'b0, 32'd0, ahb_bus_pkg::NONSEQ);
  endtask

  task automatic idle_cycle(input logic [31:0] addr);
    do_transfer(addr, 1'b0, 32'd0, ahb_bus_pkg::IDLE);
  endtask

  initial
  begin
    logic [31:0] addr;
    logic [21:0] page;
    logic [7:0]  idx;
    logic        wr;
    hreset_n   = 1'b0;
    hremap     = 1'b0;
    req        = '0;
    lfsr       = 32'h71b7_f2a9;
    wdata_next = '0;
    fail_count = 0;
    repeat (8) @(posedge hclk);
    hreset_n <= 1'b1;

    // idle transfers, one into a hole of the map
    idle_cycle(32'h0000_0C00);
    idle_cycle(take_bits(32));

    // write then read back each slave
    for (int s = 0; s < 3; s++)
    begin
      addr = (s == 2) ? 32'h0000_1000 : (32'(s) << 10);
      write_word(addr, take_bits(32));
      read_word(addr);
    end

    // unmapped write and read, SRAM words stay as they were
    do_transfer(32'h0000_0C00, 1'b1, 32'hdead_beef, ahb_bus_pkg::NONSEQ);
    read_word(32'h0000_0C04);
    read_word(32'h0000_0000);
    read_word(32'h0000_0400);
    read_word(32'h0000_1000);

    // boot remap, pages 0 and 1 trade places
    write_word(32'h0000_0014, take_bits(32));
    write_word(32'h0000_0414, take_bits(32));
    idle_cycle(32'h0);
    hremap <= 1'b1;
    read_word(32'h0000_0014);
    read_word(32'h0000_0414);
    idle_cycle(32'h0);
    hremap <= 1'b0;
    idle_cycle(32'h0);

    // back-to-back random traffic
    for (int k = 0; k < 200; k++)
    begin
      case (2'(take_bits(2)))
        2'd0:    page = 22'd0;
        2'd1:    page = 22'd1;
        2'd2:    page = 22'd4;
        default: page = (take_bits(1) != 0) ? 22'd2 : 22'd3;
      endcase
      idx  = 8'(take_bits(8));
      addr = {page, idx, 2'b00};
      wr   = (take_bits(1) != 0);
      // never read a word that was not written
      if (!wr && (slave_of(addr, 1'b0) != 2'd3) && !written[slave_of(addr, 1'b0)][idx])
        wr = 1'b1;
      if (wr)
        write_word(addr, take_bits(32));
      else
        read_word(addr);
    end
    idle_cycle(32'h0);
    idle_cycle(32'h0);

    if (fail_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* hdl/ahb_fabric_top.sv */
`timescale 1ns/1ps
// fabric top: decoder, response mux, SRAM slaves and default slave
module ahb_fabric_top
(
  input  logic                   hclk,
  input  logic                   hreset_n,
  input  logic                   hremap,
  input  ahb_bus_pkg::ahb_req_t  req,
  output ahb_bus_pkg::ahb_resp_t resp
);

  // ============================================================
  // interconnect
  // ============================================================
  ahb_map_pkg::sel_t      sel;
  logic                   default_sel;
  // fabric hready, muxed hreadyout fed back to every slave
  logic                   hready;
  ahb_bus_pkg::ahb_resp_t slave_resp [ahb_map_pkg::slave_num];
  ahb_bus_pkg::ahb_resp_t default_resp;

  assign hready = resp.hreadyout;

  // combinational decode in the address phase
  ahb_decoder ahb_decoder_inst
  (
    .hclk        (hclk),
    .hreset_n    (hreset_n),
    .req         (req),
    .hremap      (hremap),
    .sel         (sel),
    .default_sel (default_sel)
  );

  // one SRAM per region, wait states from the map
  for (genvar i = 0; i < ahb_map_pkg::slave_num; i++)
  begin : g_sram
    ahb_sram_slave
    #(
      .WAIT_STATES (ahb_map_pkg::slave_wait[i])
    )
    ahb_sram_slave_inst
    (
      .hclk     (hclk),
      .hreset_n (hreset_n),
      .hsel     (sel[i]),
      .req      (req),
      .hready   (hready),
      .resp     (slave_resp[i])
    );
  end

  // unmapped pages end here
  ahb_default_slave ahb_default_slave_inst
  (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .hsel     (default_sel),
    .req      (req),
    .hready   (hready),
    .resp     (default_resp)
  );

  ahb_resp_mux ahb_resp_mux_inst
  (
    .hclk         (hclk),
    .hreset_n     (hreset_n),
    .sel          (sel),
    .default_sel  (default_sel),
    .slave_resp   (slave_resp),
    .default_resp (default_resp),
    .resp         (resp)
  );

endmodule

/* hdl/ahb_sram_slave.sv */
`timescale 1ns/1ps
// 1 KB single-port SRAM slave, 256 words,
// data phase stretched by WAIT_STATES low cycles of hreadyout
module ahb_sram_slave
#(
  parameter int unsigned WAIT_STATES = 0
)
(
  input  logic                   hclk,
  input  logic                   hreset_n,
  input  logic                   hsel,
  input  ahb_bus_pkg::ahb_req_t  req,
  input  logic                   hready,
  output ahb_bus_pkg::ahb_resp_t resp
);

  localparam int cnt_w  = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
  localparam int words  = 256;
  localparam int idx_w  = $clog2(words);

  // ============================================================
  // internal signals
  // ============================================================
  logic [ahb_bus_pkg::data_width-1:0] mem [words];

  logic             accept;
  logic             dp_active;
  logic             dp_write;
  logic [idx_w-1:0] dp_index;
  logic [cnt_w-1:0] wait_cnt;
  logic             last;

  // address phase taken only with select, ready and a real transfer
  assign accept = hsel && hready &&
                  ((req.htrans == ahb_bus_pkg::NONSEQ) || (req.htrans == ahb_bus_pkg::SEQ));

  // final cycle of the data phase
  assign last = (wait_cnt == cnt_w'(WAIT_STATES));

  // ============================================================
  // data-phase control
  // ============================================================
  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      dp_active <= 1'b0;
      wait_cnt  <= '0;
    end
    else if (hready)
    begin
      // bus ready, previous data phase done, next one may start
      dp_active <= accept;
      wait_cnt  <= '0;
    end
    else if (dp_active && !last)
      wait_cnt <= wait_cnt + 1'b1;
  end

  // address-phase attributes for the data phase
  // word index is the offset inside the 1 KB region,
  // page bits above 9 already resolved by the decoder
  always_ff @(posedge hclk)
  begin
    if (accept)
    begin
      dp_write <= req.hwrite;
      dp_index <= req.haddr[idx_w+1:2];
    end
  end

  // ============================================================
  // memory
  // ============================================================
  // hwdata held by the master until the last cycle
  always_ff @(posedge hclk)
  begin
    if (dp_active && dp_write && last)
      mem[dp_index] <= req.hwdata;
  end

  // ============================================================
  // response
  // ============================================================
  always_comb
  begin
    resp.hreadyout = !dp_active || last;
    resp.hresp     = ahb_bus_pkg::OKAY;
    resp.hrdata    = '0;
    // read word only on the completing cycle
    if (dp_active && !dp_write && last)
      resp.hrdata = mem[dp_index];
  end

  // fabric hready follows this slave while it owns the data phase
  a_ready_forwarded: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    dp_active |-> (hready == resp.hreadyout)
  );

endmodule

/* hdl/ahb_resp_mux.sv */
`timescale 1ns/1ps
// data-phase response mux, tracks which slave owns the data phase
// and forwards that slave's response to the master
module ahb_resp_mux
(
  input  logic                   hclk,
  input  logic                   hreset_n,
  input  ahb_map_pkg::sel_t      sel,
  input  logic                   default_sel,
  input  ahb_bus_pkg::ahb_resp_t slave_resp [ahb_map_pkg::slave_num],
  input  ahb_bus_pkg::ahb_resp_t default_resp,
  output ahb_bus_pkg::ahb_resp_t resp
);

  // owner of the current data phase, all zero when nobody owns it
  typedef struct packed
  {
    ahb_map_pkg::sel_t sel;
    logic              dflt;
  } owner_t;

  owner_t                          owner;
  // per-source stall, default slave in bit 0 as in owner_t
  logic [ahb_map_pkg::slave_num:0] stall;

  // ============================================================
  // owner register
  // ============================================================
  // address phase becomes data phase only on a ready edge
  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      owner <= '0;
    else if (resp.hreadyout)
    begin
      owner.sel  <= sel;
      owner.dflt <= default_sel;
    end
  end

  // ============================================================
  // response select
  // ============================================================
  always_comb
  begin
    // no owner, idle bus answer
    resp.hrdata    = '0;
    resp.hreadyout = 1'b1;
    resp.hresp     = ahb_bus_pkg::OKAY;
    if (owner.dflt)
      resp = default_resp;
    for (int i = 0; i < ahb_map_pkg::slave_num; i++)
    begin
      if (owner.sel[i])
        resp = slave_resp[i];
    end
  end

  always_comb
  begin
    stall[0] = !default_resp.hreadyout;
    for (int i = 0; i < ahb_map_pkg::slave_num; i++)
    begin
      stall[i+1] = !slave_resp[i].hreadyout;
    end
  end

  // only the data-phase owner may hold the bus
  a_owner_held: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (stall & ~{owner.sel, owner.dflt}) == '0
  );

endmodule

/* hdl/ahb_default_slave.sv */
`timescale 1ns/1ps
// default slave, two-cycle ERROR response for unmapped accesses
module ahb_default_slave
(
  input  logic                   hclk,
  input  logic                   hreset_n,
  input  logic                   hsel,
  input  ahb_bus_pkg::ahb_req_t  req,
  input  logic                   hready,
  output ahb_bus_pkg::ahb_resp_t resp
);

  typedef enum logic
  {
    OKAY_IDLE = 1'b0,
    ERR_FIRST = 1'b1
  } err_state_t;

  err_state_t state;
  // second error cycle, hreadyout back high
  logic       err_last;
  logic       accept;

  // only NONSEQ / SEQ open an error data phase
  assign accept = hsel && hready &&
                  ((req.htrans == ahb_bus_pkg::NONSEQ) || (req.htrans == ahb_bus_pkg::SEQ));

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      state    <= OKAY_IDLE;
      err_last <= 1'b0;
    end
    else
    begin
      // hready stays low through ERR_FIRST, so no accept overlaps it
      state    <= accept ? ERR_FIRST : OKAY_IDLE;
      err_last <= (state == ERR_FIRST);
    end
  end

  // ERROR is driven on both cycles, ready only on the second
  always_comb
  begin
    resp.hrdata    = '0;
    resp.hreadyout = (state != ERR_FIRST);
    resp.hresp     = ahb_bus_pkg::OKAY;
    if ((state == ERR_FIRST) || err_last)
      resp.hresp = ahb_bus_pkg::ERROR;
  end

  a_err_second_cycle: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (state == ERR_FIRST) |=> (resp.hreadyout && (resp.hresp == ahb_bus_pkg::ERROR))
  );

endmodule

/* hdl/ahb_decoder.sv */
`timescale 1ns/1ps
// address decoder: page match against the region table,
// boot remap and per-slave / default select generation
module ahb_decoder
(
  input  logic                  hclk,
  input  logic                  hreset_n,
  input  ahb_bus_pkg::ahb_req_t req,
  input  logic                  hremap,
  output ahb_map_pkg::sel_t     sel,
  output logic                  default_sel
);

  // ============================================================
  // internal signals
  // ============================================================
  logic [ahb_map_pkg::page_w-1:0] page;
  logic [ahb_map_pkg::page_w-1:0] lo_bound [ahb_map_pkg::slave_num];
  logic [ahb_map_pkg::page_w-1:0] hi_bound [ahb_map_pkg::slave_num];
  ahb_map_pkg::sel_t              match;
  logic                           active;

  // page number of the current address phase
  assign page = req.haddr[ahb_bus_pkg::addr_width-1:ahb_map_pkg::page_lsb];

  // IDLE and BUSY never select anything
  assign active = (req.htrans == ahb_bus_pkg::NONSEQ) ||
                  (req.htrans == ahb_bus_pkg::SEQ);

  // ============================================================
  // region bounds with remap
  // ============================================================
  always_comb
  begin
    for (int i = 0; i < ahb_map_pkg::slave_num; i++)
    begin
      lo_bound[i] = ahb_map_pkg::region_low[i];
      hi_bound[i] = ahb_map_pkg::region_high[i];
    end
    // boot remap, exchange the two paired regions
    if (hremap)
    begin
      lo_bound[ahb_map_pkg::remap_a] = ahb_map_pkg::region_low[ahb_map_pkg::remap_b];
      hi_bound[ahb_map_pkg::remap_a] = ahb_map_pkg::region_high[ahb_map_pkg::remap_b];
      lo_bound[ahb_map_pkg::remap_b] = ahb_map_pkg::region_low[ahb_map_pkg::remap_a];
      hi_bound[ahb_map_pkg::remap_b] = ahb_map_pkg::region_high[ahb_map_pkg::remap_a];
    end
  end

  // ============================================================
  // match and selects
  // ============================================================
  always_comb
  begin
    for (int i = 0; i < ahb_map_pkg::slave_num; i++)
    begin
      match[i] = (page >= lo_bound[i]) && (page < hi_bound[i]);
    end
  end

  assign sel = active ? match : '0;

  // real transfer into a hole of the map
  assign default_sel = active && !(|match);

  // catches overlapping entries in the table, with and without remap
  a_sel_exclusive: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    $onehot0({sel, default_sel})
  );

endmodule

/* hdl/ahb_map_pkg.sv */
// address map of the fabric: slave count, 1 KB regions,
// boot remap pairing and per-slave wait states
package ahb_map_pkg;

  localparam int slave_num = 3;

  // 1 KB granule, regions are whole pages
  localparam int page_lsb = 10;
  localparam int page_w   = ahb_bus_pkg::addr_width - page_lsb;

  // ============================================================
  // region table, in page numbers
  // ============================================================
  // low inclusive, high exclusive
  // pages 2 and 3 stay unmapped
  localparam logic [page_w-1:0] region_low [slave_num] = '{22'd0, 22'd1, 22'd4};
  localparam logic [page_w-1:0] region_high [slave_num] = '{22'd1, 22'd2, 22'd5};

  // boot remap swaps these two regions
  localparam int unsigned remap_a = 0;
  localparam int unsigned remap_b = 1;

  // wait states per SRAM slave
  localparam int unsigned slave_wait [slave_num] = '{0, 1, 2};

  // one select bit per slave
  typedef logic [slave_num-1:0] sel_t;

endpackage

/* hdl/ahb_bus_pkg.sv */
// AHB-Lite widths, transfer encodings
// and the request/response structs carried between master and slaves
package ahb_bus_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int addr_width = 32;
  localparam int data_width = 32;

  // ============================================================
  // encodings
  // ============================================================
  // transfer type, only NONSEQ and SEQ move data
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // transfer size, the slaves handle WORD only
  typedef enum logic [2:0]
  {
    BYTE             = 3'b000,
    HALFWORD         = 3'b001,
    WORD             = 3'b010,
    DOUBLEWORD       = 3'b011,
    FOURWORDLINE     = 3'b100,
    EIGHTWORDLINE    = 3'b101,
    SIXTEENWORDLINE  = 3'b110,
    THIRTY2WORDLINE  = 3'b111
  } hsize_t;

  // no SPLIT or RETRY on AHB-Lite
  typedef enum logic
  {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

  // ============================================================
  // bundles
  // ============================================================
  // master address phase plus the write data of its data phase
  typedef struct packed
  {
    logic [addr_width-1:0] haddr;
    htrans_t               htrans;
    logic                  hwrite;
    hsize_t                hsize;
    logic [data_width-1:0] hwdata;
  } ahb_req_t;

  // one slave's response
  typedef struct packed
  {
    logic [data_width-1:0] hrdata;
    logic                  hreadyout;
    hresp_t                hresp;
  } ahb_resp_t;

endpackage
